// File: Bender.yml
package:
  name: hack_cpu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - hack_isa_pkg.sv
      - cpu_ctrl_pkg.sv
      - hack_alu.sv
      - ad_registers.sv
      - pc_unit.sv
      - cpu_control.sv
      - hack_cpu.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_hack_cpu.sv

// File: ad_registers.sv
`timescale 1ns/10ps
`default_nettype none
`include "hack_config.svh"

module ad_registers (
    input  wire logic                    clk,
    input  wire logic                    resetN,
    input  wire logic                    load_a,
    input  wire logic                    load_d,
    input  wire logic                    load_imm,
    input  wire logic [`HACK_ADDR_W-1:0] imm,
    input  wire logic                    sel_m,
    input  wire logic [`HACK_WORD_W-1:0] alu_out,
    input  wire logic [`HACK_WORD_W-1:0] in_m,
    output logic      [`HACK_WORD_W-1:0] a_value,
    output logic      [`HACK_WORD_W-1:0] d_value,
    output logic      [`HACK_WORD_W-1:0] alu_y
);

    // value that A takes when load_a is set
    logic [`HACK_WORD_W-1:0] a_next;

    // an A-instruction loads its constant with a zero msb
    // a C-instruction with the A destination loads the ALU result
    assign a_next = load_imm ? {1'b0, imm} : alu_out;

    // A and D only move in EXECUTE, the strobes are quiet otherwise
    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            a_value <= '0;
            d_value <= '0;
        end
        else
        begin
            if (load_a)
                a_value <= a_next;
            if (load_d)
                d_value <= alu_out;
        end
    end

    // second ALU operand is A itself or the RAM word that A points to
    // in_m is valid in EXECUTE since A was on the read address one cycle earlier
    assign alu_y = sel_m ? in_m : a_value;

endmodule

`default_nettype wire

// File: cpu_control.sv
`timescale 1ns/10ps
`default_nettype none
`include "hack_config.svh"

module cpu_control
    import hack_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    resetN,
    input  wire logic [`HACK_ROM_W-1:0]  inst,
    input  wire logic                    pc_low,
    input  wire logic [`HACK_PC_W-1:0]   next_pc,
    output logic      [`HACK_ROM_AW-1:0] inst_addr,
    output logic                         exec_en,
    output logic                         sel_m,
    output alu_fn_e                      alu_fn,
    output logic                         load_a,
    output logic                         load_d,
    output logic                         load_imm,
    output logic      [`HACK_ADDR_W-1:0] imm,
    output logic                         write_m,
    output logic                         jmp_lt,
    output logic                         jmp_eq,
    output logic                         jmp_gt
);

    cpu_state_e state;

    // registered ROM word address, follows the program counter
    logic [`HACK_ROM_AW-1:0] fetch_addr_q;
    // the single instruction being worked on
    logic [`HACK_WORD_W-1:0] ir;

    inst_kind_e kind;
    jump_cond_e jcond;
    logic       c_exec;

    // ****************************************
    // instruction cycle FSM
    // ****************************************

    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            state        <= FETCH;
            fetch_addr_q <= '0;
        end
        else
        begin
            case (state)
                FETCH:
                    state <= DECODE;
                DECODE:
                    state <= EXECUTE;
                EXECUTE:
                begin
                    state <= FETCH;
                    // pc_unit loads the same next_pc at this edge
                    fetch_addr_q <= next_pc[`HACK_PC_W-1:1];
                end
                default:
                    state <= FETCH;
            endcase
        end
    end

    // the ROM answers in DECODE for the address presented in FETCH
    assign inst_addr = fetch_addr_q;

    // pc bit 0 picks the high or the low instruction of the ROM word
    always_ff @(posedge clk)
    begin
        if (state == DECODE)
            ir <= pc_low ? inst[`HACK_ROM_W-1:`HACK_WORD_W] : inst[`HACK_WORD_W-1:0];
    end

    // ****************************************
    // decode
    // ****************************************

    assign kind  = inst_kind_e'(ir[`HACK_BIT_C]);
    assign jcond = jump_cond_e'(ir[`HACK_JLT:`HACK_JGT]);

    // levels straight from the instruction register
    assign alu_fn = alu_fn_e'(ir[`HACK_COMP_LSB +: 6]);
    assign imm    = ir[`HACK_ADDR_W-1:0];
    // bit 12 is part of the constant in an A-instruction, so qualify it
    assign sel_m  = (kind == C_INST) && ir[`HACK_BIT_AM];

    // strobes are single cycle and only live in EXECUTE
    assign exec_en = (state == EXECUTE);
    assign c_exec  = exec_en && (kind == C_INST);

    // an A-instruction always writes its constant into A
    assign load_imm = exec_en && (kind == A_INST);
    assign load_a   = load_imm || (c_exec && ir[`HACK_DEST_A]);
    assign load_d   = c_exec && ir[`HACK_DEST_D];
    assign write_m  = c_exec && ir[`HACK_DEST_M];

    assign jmp_lt = c_exec && (jcond inside {JMP_JLT, JMP_JNE, JMP_JLE, JMP_JMP});
    assign jmp_eq = c_exec && (jcond inside {JMP_JEQ, JMP_JGE, JMP_JLE, JMP_JMP});
    assign jmp_gt = c_exec && (jcond inside {JMP_JGT, JMP_JGE, JMP_JNE, JMP_JMP});

endmodule

`default_nettype wire

// File: cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    // one instruction at a time walks through these three states
    // FETCH drives the ROM address
    // DECODE captures the ROM answer into the instruction register
    // EXECUTE runs the ALU and updates A, D, RAM and the program counter
    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        DECODE  = 2'd1,
        EXECUTE = 2'd2
    } cpu_state_e;

endpackage

`default_nettype wire

// File: hack_alu.sv
`timescale 1ns/10ps
`default_nettype none
`include "hack_config.svh"

module hack_alu
    import hack_isa_pkg::*;
(
    input  wire logic [`HACK_WORD_W-1:0] x,
    input  wire logic [`HACK_WORD_W-1:0] y,
    input  wire alu_fn_e                 fn,
    output logic      [`HACK_WORD_W-1:0] alu_out,
    output logic                         zero,
    output logic                         negative
);

    // control bits of the comp code, named after the Hack spec
    logic zx, nx, zy, ny, f, no;

    // operands after the zero and negate steps
    logic [`HACK_WORD_W-1:0] x_z, x_n, y_z, y_n;
    // result of the add or AND step before the output negate
    logic [`HACK_WORD_W-1:0] f_out;

    assign {zx, nx, zy, ny, f, no} = fn;

    // ****************************************
    // input conditioning
    // ****************************************

    // zero first, then invert, so zx plus nx gives all ones
    assign x_z = zx ? '0 : x;
    assign x_n = nx ? ~x_z : x_z;
    assign y_z = zy ? '0 : y;
    assign y_n = ny ? ~y_z : y_z;

    // ****************************************
    // function and output negate
    // ****************************************

    // the add wraps modulo 2^16, the carry out is dropped
    assign f_out   = f ? (x_n + y_n) : (x_n & y_n);
    assign alu_out = no ? ~f_out : f_out;

    // flags come from the final result and feed the jump decision
    assign zero     = (alu_out == '0);
    assign negative = alu_out[`HACK_WORD_W-1];

endmodule

`default_nettype wire

// File: hack_config.svh
`ifndef HACK_CONFIG_SVH
`define HACK_CONFIG_SVH

// data word width shared by A, D, the ALU and the RAM data buses
`define HACK_WORD_W 16
// RAM address width, which is also the width of an A-instruction constant
`define HACK_ADDR_W 15
// the program counter counts single 16-bit instructions
`define HACK_PC_W 15
// every ROM word packs two instructions, the low half comes first
`define HACK_ROM_W 32
// ROM word address is the program counter without its low bit
`define HACK_ROM_AW 14

// field positions inside one 16-bit instruction
`define HACK_BIT_C 15
`define HACK_BIT_AM 12
`define HACK_COMP_LSB 6
`define HACK_DEST_A 5
`define HACK_DEST_D 4
`define HACK_DEST_M 3
`define HACK_JLT 2
`define HACK_JEQ 1
`define HACK_JGT 0

`endif

// File: hack_cpu.sv
`timescale 1ns/10ps
`default_nettype none
`include "hack_config.svh"

module hack_cpu
    import hack_isa_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    resetN,
    input  wire logic [`HACK_ROM_W-1:0]  inst,
    input  wire logic [`HACK_WORD_W-1:0] in_m,
    output logic      [`HACK_ROM_AW-1:0] inst_addr,
    output logic      [`HACK_ADDR_W-1:0] read_data_addr,
    output logic      [`HACK_ADDR_W-1:0] write_data_addr,
    output logic      [`HACK_WORD_W-1:0] out_m,
    output logic                         write_m
);

    // ****************************************
    // control to datapath
    // ****************************************

    logic                    exec_en;
    logic                    sel_m;
    alu_fn_e                 alu_fn;
    logic                    load_a;
    logic                    load_d;
    logic                    load_imm;
    logic [`HACK_ADDR_W-1:0] imm;
    logic                    jmp_lt;
    logic                    jmp_eq;
    logic                    jmp_gt;

    // datapath values and flags
    logic [`HACK_WORD_W-1:0] a_value;
    logic [`HACK_WORD_W-1:0] d_value;
    logic [`HACK_WORD_W-1:0] alu_y;
    logic [`HACK_WORD_W-1:0] alu_out;
    logic                    zero;
    logic                    negative;
    logic [`HACK_PC_W-1:0]   pc;
    logic [`HACK_PC_W-1:0]   next_pc;

    cpu_control u_control (
        .clk       (clk),
        .resetN    (resetN),
        .inst      (inst),
        .pc_low    (pc[0]),
        .next_pc   (next_pc),
        .inst_addr (inst_addr),
        .exec_en   (exec_en),
        .sel_m     (sel_m),
        .alu_fn    (alu_fn),
        .load_a    (load_a),
        .load_d    (load_d),
        .load_imm  (load_imm),
        .imm       (imm),
        .write_m   (write_m),
        .jmp_lt    (jmp_lt),
        .jmp_eq    (jmp_eq),
        .jmp_gt    (jmp_gt)
    );

    ad_registers u_regs (
        .clk      (clk),
        .resetN   (resetN),
        .load_a   (load_a),
        .load_d   (load_d),
        .load_imm (load_imm),
        .imm      (imm),
        .sel_m    (sel_m),
        .alu_out  (alu_out),
        .in_m     (in_m),
        .a_value  (a_value),
        .d_value  (d_value),
        .alu_y    (alu_y)
    );

    // x is always D, y is A or M
    hack_alu u_alu (
        .x        (d_value),
        .y        (alu_y),
        .fn       (alu_fn),
        .alu_out  (alu_out),
        .zero     (zero),
        .negative (negative)
    );

    pc_unit u_pc (
        .clk      (clk),
        .resetN   (resetN),
        .exec_en  (exec_en),
        .zero     (zero),
        .negative (negative),
        .jmp_lt   (jmp_lt),
        .jmp_eq   (jmp_eq),
        .jmp_gt   (jmp_gt),
        .a_value  (a_value),
        .pc       (pc),
        .next_pc  (next_pc)
    );

    // A addresses RAM for both reads and writes
    // the read in DECODE returns M in time for EXECUTE
    assign read_data_addr  = a_value[`HACK_ADDR_W-1:0];
    assign write_data_addr = a_value[`HACK_ADDR_W-1:0];
    assign out_m           = alu_out;

endmodule

`default_nettype wire

// File: hack_isa_pkg.sv
`default_nettype none

package hack_isa_pkg;

    // bit 15 of an instruction tells the two kinds apart
    typedef enum logic {
        A_INST = 1'b0,
        C_INST = 1'b1
    } inst_kind_e;

    // comp field without the a bit, ordered zx nx zy ny f no from msb to lsb
    // y stands for A or M, whichever the a bit selects
    typedef enum logic [5:0] {
        ALU_ZERO          = 6'b101010,
        ALU_ONE           = 6'b111111,
        ALU_MINUS_ONE     = 6'b111010,
        ALU_D             = 6'b001100,
        ALU_Y             = 6'b110000,
        ALU_NOT_D         = 6'b001101,
        ALU_NOT_Y         = 6'b110001,
        ALU_NEG_D         = 6'b001111,
        ALU_NEG_Y         = 6'b110011,
        ALU_D_PLUS_ONE    = 6'b011111,
        ALU_Y_PLUS_ONE    = 6'b110111,
        ALU_D_MINUS_ONE   = 6'b001110,
        ALU_Y_MINUS_ONE   = 6'b110010,
        ALU_D_PLUS_Y      = 6'b000010,
        ALU_D_MINUS_Y     = 6'b010011,
        ALU_Y_MINUS_D     = 6'b000111,
        ALU_D_AND_Y       = 6'b000000,
        ALU_D_OR_Y        = 6'b010101
    } alu_fn_e;

    // jump field, one bit each for less than, equal and greater than zero
    typedef enum logic [2:0] {
        JMP_NONE = 3'b000,
        JMP_JGT  = 3'b001,
        JMP_JEQ  = 3'b010,
        JMP_JGE  = 3'b011,
        JMP_JLT  = 3'b100,
        JMP_JNE  = 3'b101,
        JMP_JLE  = 3'b110,
        JMP_JMP  = 3'b111
    } jump_cond_e;

endpackage

`default_nettype wire

// File: pc_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "hack_config.svh"

module pc_unit (
    input  wire logic                    clk,
    input  wire logic                    resetN,
    input  wire logic                    exec_en,
    input  wire logic                    zero,
    input  wire logic                    negative,
    input  wire logic                    jmp_lt,
    input  wire logic                    jmp_eq,
    input  wire logic                    jmp_gt,
    input  wire logic [`HACK_WORD_W-1:0] a_value,
    output logic      [`HACK_PC_W-1:0]   pc,
    output logic      [`HACK_PC_W-1:0]   next_pc
);

    // result is strictly positive when it is neither zero nor negative
    logic positive;
    // jump decision for the instruction in EXECUTE
    logic taken;

    assign positive = !(zero || negative);

    // the jump bits are ORed, so JGE or JNE or JMP fall out naturally
    // jump strobes are only raised in EXECUTE for a C-instruction
    assign taken = (jmp_lt && negative) ||
                   (jmp_eq && zero)     ||
                   (jmp_gt && positive);

    // the target is the A value before this instruction updates it
    // A holds an instruction address here, so bit 15 is ignored
    assign next_pc = taken ? a_value[`HACK_PC_W-1:0] : pc + 1'b1;

    // pc advances once per instruction, at the end of EXECUTE
    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
            pc <= '0;
        else if (exec_en)
            pc <= next_pc;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
hack_isa_pkg.sv
cpu_ctrl_pkg.sv
hack_alu.sv
ad_registers.sv
pc_unit.sv
cpu_control.sv
hack_cpu.sv
tb_hack_cpu.sv

// File: tb_hack_tests.svh
`ifndef TB_HACK_TESTS_SVH
`define TB_HACK_TESTS_SVH

// no write and a zero ROM address while in reset and right after it
task test_reset;
    int k;
    start_test("reset");
    fill_memories();
    for (k = 0; k < RST_CYCLES; k++)
    begin
        @(posedge clk);
        #1;
        compare_value("write_m in reset", 0, write_m);
        compare_value("inst_addr in reset", 0, inst_addr);
    end
    resetN = 1'b1;
    #1;
    compare_value("write_m after reset", 0, write_m);
    compare_value("inst_addr after reset", 0, inst_addr);
    repeat (3 * N_RESET) @(posedge clk);
    #1;
    finish_test();
endtask

// @k, D=A, @addr, M=D
task test_const_store;
    logic [14:0] k_val;
    logic [14:0] addr;
    start_test("const_store");
    k_val = 15'($urandom);
    addr  = 15'($urandom);
    load_reset();
    place_instr(0, encode_a(k_val));
    place_instr(1, encode_c(1'b0, 6'b110000, 3'b010, 3'b000));
    place_instr(2, encode_a(addr));
    place_instr(3, encode_c(1'b0, 6'b001100, 3'b001, 3'b000));
    run_program(N_CONST);
    compare_value("ram word", {1'b0, k_val}, ram[addr]);
    compare_value("write count", 1, log_cyc.size());
    if (log_cyc.size() > 0)
    begin
        compare_value("write addr", addr, log_addr[0]);
        // the fourth instruction writes in its third cycle
        compare_value("write cycle", 3 * 3 + 2, log_cyc[0]);
    end
    finish_test();
endtask

// A doubles as y operand and store address, so M=comp writes RAM[A]
task test_alu;
    int          i;
    logic [14:0] dv;
    logic [14:0] base;
    logic [14:0] av;
    logic [15:0] d_exp;
    logic        neg_d;
    start_test("alu_functions");
    dv    = 15'($urandom);
    base  = 15'($urandom);
    neg_d = 1'($urandom);
    load_reset();
    place_instr(0, encode_a(dv));
    place_instr(1, encode_c(1'b0, neg_d ? 6'b110001 : 6'b110000, 3'b010, 3'b000));
    for (i = 0; i < 18; i++)
    begin
        av = {base[14:5], 5'(i)};
        place_instr(2 + 2 * i, encode_a(av));
        place_instr(3 + 2 * i, encode_c(1'b0, comp_code(i), 3'b001, 3'b000));
    end
    run_program(N_ALU);
    d_exp = neg_d ? ~{1'b0, dv} : {1'b0, dv};
    for (i = 0; i < 18; i++)
    begin
        av = {base[14:5], 5'(i)};
        compare_value($sformatf("comp %0d", i), expected_comp(i, d_exp, {1'b0, av}), ram[av]);
    end
    compare_value("write count", 18, log_cyc.size());
    finish_test();
endtask

// M=D+M on a preloaded word, then A=M follows a pointer for M=D
task test_m_operand;
    logic [14:0] dv;
    logic [14:0] addr;
    logic [14:0] addr2;
    logic [14:0] ptr;
    logic [15:0] mval;
    logic [15:0] sum;
    start_test("m_operand");
    dv    = 15'($urandom);
    mval  = 16'($urandom);
    addr  = 15'($urandom);
    addr2 = addr ^ 15'h0001;
    ptr   = addr ^ 15'h0002;
    load_reset();
    ram[addr]  = mval;
    ram[addr2] = {1'b0, ptr};
    place_instr(0, encode_a(dv));
    place_instr(1, encode_c(1'b0, 6'b110000, 3'b010, 3'b000));
    place_instr(2, encode_a(addr));
    place_instr(3, encode_c(1'b1, 6'b000010, 3'b001, 3'b000));
    place_instr(4, encode_a(addr2));
    place_instr(5, encode_c(1'b1, 6'b110000, 3'b100, 3'b000));
    place_instr(6, encode_c(1'b0, 6'b001100, 3'b001, 3'b000));
    run_program(N_MOP);
    sum = mval + {1'b0, dv};
    compare_value("sum word", sum, ram[addr]);
    compare_value("pointer word", {1'b0, dv}, ram[ptr]);
    compare_value("write count", 2, log_cyc.size());
    // A still holds the pointer loaded from RAM, and the read bus follows A
    compare_value("read address", ptr, read_data_addr);
    finish_test();
endtask

// each case sets D, jumps on D, and both paths store their own marker
task test_jumps;
    int          c;
    logic [14:0] v;
    logic [14:0] target;
    logic [14:0] mark_t;
    logic [14:0] mark_nt;
    logic [2:0]  jbits;
    logic [5:0]  dcomp;
    logic [15:0] d_exp;
    start_test("jumps");
    for (c = 0; c < N_JUMP_RUNS; c++)
    begin
        // lt, eq, gt in pairs, the D sign rotates negative, positive, zero
        jbits   = (c / 2 == 0) ? 3'b100 : (c / 2 == 1) ? 3'b010 : 3'b001;
        v       = 15'($urandom) | 15'h0001;
        dcomp   = (c % 3 == 0) ? 6'b110001 : (c % 3 == 1) ? 6'b110000 : 6'b101010;
        d_exp   = (c % 3 == 0) ? ~{1'b0, v} : (c % 3 == 1) ? {1'b0, v} : 16'h0000;
        // even targets sit in the low half, odd ones in the high half
        // the taken cases land in both halves
        target  = 15'(8 + (c / 2) % 2);
        mark_t  = 15'h2a00 + 15'(c);
        mark_nt = 15'h1500 + 15'(c);
        load_reset();
        place_instr(0, encode_a(v));
        place_instr(1, encode_c(1'b0, dcomp, 3'b010, 3'b000));
        place_instr(2, encode_a(target));
        place_instr(3, encode_c(1'b0, 6'b001100, 3'b000, jbits));
        place_instr(4, encode_a(mark_nt));
        place_instr(5, encode_c(1'b0, 6'b110000, 3'b010, 3'b000));
        place_instr(6, encode_a(RESULT_ADDR));
        place_instr(7, encode_c(1'b0, 6'b001100, 3'b001, 3'b000));
        place_instr(target, encode_a(mark_t));
        place_instr(target + 1, encode_c(1'b0, 6'b110000, 3'b010, 3'b000));
        place_instr(target + 2, encode_a(RESULT_ADDR));
        place_instr(target + 3, encode_c(1'b0, 6'b001100, 3'b001, 3'b000));
        run_program(N_JUMP);
        compare_value($sformatf("case %0d marker", c),
                      jump_taken(jbits, d_exp) ? {1'b0, mark_t} : {1'b0, mark_nt},
                      ram[RESULT_ADDR]);
        compare_value($sformatf("case %0d write count", c), 1, log_cyc.size());
    end
    finish_test();
endtask

// AM=A+1 repeated, every instruction after the first stores
task test_throughput;
    int          i;
    logic [14:0] base;
    start_test("throughput");
    base = 15'($urandom) & 15'h3fff;
    load_reset();
    place_instr(0, encode_a(base));
    for (i = 1; i <= N_STORES; i++)
        place_instr(i, encode_c(1'b0, 6'b110111, 3'b101, 3'b000));
    run_program(N_THRU);
    compare_value("write count", N_STORES, log_cyc.size());
    for (i = 0; i < log_cyc.size(); i++)
    begin
        compare_value($sformatf("write %0d addr", i), 15'(base + i), log_addr[i]);
        compare_value($sformatf("write %0d data", i), 16'(base + i + 1), log_data[i]);
        compare_value($sformatf("write %0d cycle", i), 3 * (i + 1) + 2, log_cyc[i]);
        if (i > 0)
            compare_value($sformatf("write %0d gap", i), 3, log_cyc[i] - log_cyc[i - 1]);
    end
    finish_test();
endtask

`endif

// File: tb_hack_cpu.sv
`timescale 1ns/10ps
`default_nettype none
`include "hack_config.svh"

module tb_hack_cpu;

    // clock period in ns and length of the first reset in cycles
    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 10;
    // reset cycles in front of every later run
    localparam int RST_GAP = 3;
    localparam int SEED = 4;

    // instructions executed per run, these set the run lengths and the watchdog
    localparam int N_RESET     = 1;
    localparam int N_CONST     = 4;
    localparam int N_ALU       = 38;
    localparam int N_MOP       = 7;
    localparam int N_JUMP      = 8;
    localparam int N_JUMP_RUNS = 6;
    localparam int N_STORES    = 8;
    localparam int N_THRU      = N_STORES + 1;
    localparam int TOTAL_INSTR = N_RESET + N_CONST + N_ALU + N_MOP
                               + N_JUMP * N_JUMP_RUNS + N_THRU;
    localparam int N_RUNS      = 4 + N_JUMP_RUNS;
    localparam int TIMEOUT_NS  = (TOTAL_INSTR * 3 + RST_CYCLES + N_RUNS * (RST_GAP + 2))
                               * CLK_PERIOD + 400;

    // RAM word where the jump programs leave their marker
    localparam logic [`HACK_ADDR_W-1:0] RESULT_ADDR = 15'h1234;

    logic                     clk;
    logic                     resetN;
    logic [`HACK_ROM_W-1:0]   inst;
    logic [`HACK_WORD_W-1:0]  in_m;
    logic [`HACK_ROM_AW-1:0]  inst_addr;
    logic [`HACK_ADDR_W-1:0]  read_data_addr;
    logic [`HACK_ADDR_W-1:0]  write_data_addr;
    logic [`HACK_WORD_W-1:0]  out_m;
    logic                     write_m;

    // instruction ROM and data RAM images
    logic [`HACK_ROM_W-1:0]  rom [0:(1 << `HACK_ROM_AW) - 1];
    logic [`HACK_WORD_W-1:0] ram [0:(1 << `HACK_ADDR_W) - 1];

    // every RAM write with the cycle it happened in, counted from reset release
    int                      log_cyc [$];
    logic [`HACK_ADDR_W-1:0] log_addr [$];
    logic [`HACK_WORD_W-1:0] log_data [$];
    int                      cyc;

    // memory answers sampled at the edge, driven a little later
    logic [`HACK_ROM_W-1:0]  rom_q;
    logic [`HACK_WORD_W-1:0] ram_q;

    string cur_test;
    int    errors;
    int    err_mark;
    int    tests_pass;
    int    tests_fail;

    hack_cpu u_dut (
        .clk             (clk),
        .resetN          (resetN),
        .inst            (inst),
        .in_m            (in_m),
        .inst_addr       (inst_addr),
        .read_data_addr  (read_data_addr),
        .write_data_addr (write_data_addr),
        .out_m           (out_m),
        .write_m         (write_m)
    );

    initial
        clk = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ****************************************
    // ROM and RAM models
    // ****************************************

    // both memories answer one cycle after the address, writes land at the edge
    always @(posedge clk)
    begin
        rom_q = rom[inst_addr];
        ram_q = ram[read_data_addr];
        if (!resetN)
            cyc = 0;
        else
        begin
            if (write_m)
            begin
                ram[write_data_addr] = out_m;
                log_cyc.push_back(cyc);
                log_addr.push_back(write_data_addr);
                log_data.push_back(out_m);
            end
            cyc = cyc + 1;
        end
        #1;
        inst = rom_q;
        in_m = ram_q;
    end

    // ****************************************
    // instruction encoding and reference model
    // ****************************************

    function automatic logic [15:0] encode_a(input logic [14:0] value);
        return {1'b0, value};
    endfunction

    // a bit, comp, dest as A D M, jump as lt eq gt
    function automatic logic [15:0] encode_c(input logic am, input logic [5:0] comp,
                                             input logic [2:0] dest, input logic [2:0] jump);
        return {3'b111, am, comp, dest, jump};
    endfunction

    // the eighteen standard comp codes in a fixed order
    function automatic logic [5:0] comp_code(input int idx);
        case (idx)
            0:       return 6'b101010;
            1:       return 6'b111111;
            2:       return 6'b111010;
            3:       return 6'b001100;
            4:       return 6'b110000;
            5:       return 6'b001101;
            6:       return 6'b110001;
            7:       return 6'b001111;
            8:       return 6'b110011;
            9:       return 6'b011111;
            10:      return 6'b110111;
            11:      return 6'b001110;
            12:      return 6'b110010;
            13:      return 6'b000010;
            14:      return 6'b010011;
            15:      return 6'b000111;
            16:      return 6'b000000;
            default: return 6'b010101;
        endcase
    endfunction

    // what each comp means in arithmetic terms, all sums wrap at 16 bits
    function automatic logic [15:0] expected_comp(input int idx, input logic [15:0] d,
                                                  input logic [15:0] y);
        case (idx)
            0:       return 16'h0000;
            1:       return 16'h0001;
            2:       return 16'hffff;
            3:       return d;
            4:       return y;
            5:       return ~d;
            6:       return ~y;
            7:       return -d;
            8:       return -y;
            9:       return d + 16'd1;
            10:      return y + 16'd1;
            11:      return d - 16'd1;
            12:      return y - 16'd1;
            13:      return d + y;
            14:      return d - y;
            15:      return y - d;
            16:      return d & y;
            default: return d | y;
        endcase
    endfunction

    // lt needs a negative result, eq a zero one, gt one that is neither
    function automatic logic jump_taken(input logic [2:0] jump, input logic [15:0] result);
        logic neg;
        logic zer;
        neg = result[15];
        zer = (result == 16'h0000);
        return (jump[2] && neg) || (jump[1] && zer) || (jump[0] && !neg && !zer);
    endfunction

    // ****************************************
    // test helpers
    // ****************************************

    task compare_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            errors = errors + 1;
        end
    endtask

    task start_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task finish_test;
        if (errors == err_mark)
        begin
            tests_pass = tests_pass + 1;
            $display("test %s: PASS", cur_test);
        end
        else
        begin
            tests_fail = tests_fail + 1;
            $display("test %s: FAIL with %0d errors", cur_test, errors - err_mark);
        end
    endtask

    // unused ROM words hold A-instructions, so a stray fetch never writes RAM
    task fill_memories;
        int i;
        for (i = 0; i < (1 << `HACK_ROM_AW); i++)
            rom[i] = {2'b00, i[13:0], 2'b00, ~i[13:0]};
        for (i = 0; i < (1 << `HACK_ADDR_W); i++)
            ram[i] = {i[14:0], 1'b1} ^ 16'ha5c3;
    endtask

    // hold the DUT in reset while a new program is written
    task load_reset;
        @(posedge clk);
        #1;
        resetN = 1'b0;
        log_cyc.delete();
        log_addr.delete();
        log_data.delete();
        fill_memories();
    endtask

    task place_instr(input int idx, input logic [15:0] instr);
        if (idx % 2 == 1)
            rom[idx / 2][31:16] = instr;
        else
            rom[idx / 2][15:0] = instr;
    endtask

    // every instruction takes three cycles, so the run length is fixed
    task run_program(input int n_instr);
        repeat (RST_GAP) @(posedge clk);
        #1;
        resetN = 1'b1;
        repeat (3 * n_instr) @(posedge clk);
        #1;
    endtask

    `include "tb_hack_tests.svh"

    initial
    begin
        resetN     = 1'b0;
        inst       = '0;
        in_m       = '0;
        errors     = 0;
        err_mark   = 0;
        tests_pass = 0;
        tests_fail = 0;
        cyc        = 0;
        void'($urandom(SEED));
        test_reset();
        test_const_store();
        test_alu();
        test_m_operand();
        test_jumps();
        test_throughput();
        $display("tests passed: %0d, failed: %0d, errors: %0d", tests_pass, tests_fail, errors);
        if (errors == 0 && tests_fail == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // watchdog sized from the instruction counts above
    initial
    begin
        #(TIMEOUT_NS);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
